/* src/frame_link_pkg.sv */
package frame_link_pkg;

    //////////////////////////////
    // vector types
    typedef logic [7:0]  pixel_byte_t;
    typedef logic [15:0] coord_t;
    typedef logic [15:0] cmd_addr_t;
    typedef logic [31:0] cmd_data_t;

    // channel 0 sits in the upper byte
    typedef struct packed {
        pixel_byte_t ch0;
        pixel_byte_t ch1;
    } stereo_pixel_t;

    // one cropped pixel with its frame start mark
    typedef struct packed {
        stereo_pixel_t pix;
        logic          sof;
    } pixel_beat_t;

    // address goes out first on the host link
    typedef struct packed {
        cmd_addr_t addr;
        cmd_data_t data;
    } command_t;

    typedef enum logic {
        HEADER,
        PIXEL
    } ser_state_t;

    //////////////////////////////
    // command address map
    localparam cmd_addr_t ADDR_ROI_COL   = 16'h0000;
    localparam cmd_addr_t ADDR_ROI_ROW   = 16'h0001;
    localparam cmd_addr_t ADDR_STREAM_EN = 16'h0002;

    // "BIVFRAME", msb first on the wire
    localparam logic [63:0] MAGIC_NUM = 64'h42_49_56_46_52_41_4D_45;

    localparam int CMD_BYTES = 6;

endpackage

/* src/command_assembler.sv */
module command_assembler (
    input  logic                      core_clk,
    input  logic                      sys_reset,

    input  frame_link_pkg::pixel_byte_t host_byte_i,
    input  logic                      host_valid_i,

    output frame_link_pkg::command_t  cmd_o,
    output logic                      cmd_valid_o
);
    import frame_link_pkg::*;

    localparam int CMD_W = $bits(command_t);

    logic [CMD_W-1:0] shift_q;
    logic [2:0]       byte_cnt_q;
    logic             last_byte;

    assign last_byte = (byte_cnt_q == 3'(CMD_BYTES - 1));

    // msb first, so older bytes move up
    always_ff @(posedge core_clk) begin
        if (host_valid_i) begin
            shift_q <= {shift_q[CMD_W-9:0], host_byte_i};
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            byte_cnt_q  <= '0;
            cmd_valid_o <= 1'b0;
        end else begin
            cmd_valid_o <= host_valid_i && last_byte;
            if (host_valid_i) begin
                if (last_byte) begin
                    byte_cnt_q <= '0;
                end else begin
                    byte_cnt_q <= byte_cnt_q + 3'd1;
                end
            end
        end
    end

    // word is complete in the same cycle as the strobe
    assign cmd_o = command_t'(shift_q);

endmodule

/* src/roi_registers.sv */
module roi_registers #(
    parameter int IMAGE_WIDTH  = 16,
    parameter int IMAGE_HEIGHT = 6,
    parameter int ROI_WIDTH    = 10,
    parameter int ROI_HEIGHT   = 4
) (
    input  logic                     core_clk,
    input  logic                     sys_reset,

    input  frame_link_pkg::command_t cmd_i,
    input  logic                     cmd_valid_i,

    output frame_link_pkg::coord_t   roi_col_o,
    output frame_link_pkg::coord_t   roi_row_o,
    output logic                     stream_en_o
);
    import frame_link_pkg::*;

    // largest corner that keeps the window inside the image
    localparam int MAX_COL = IMAGE_WIDTH - ROI_WIDTH;
    localparam int MAX_ROW = IMAGE_HEIGHT - ROI_HEIGHT;

    // default window is centred horizontally, top aligned
    localparam coord_t DEFAULT_COL = coord_t'(MAX_COL / 2);
    localparam coord_t DEFAULT_ROW = '0;

    logic col_ok;
    logic row_ok;

    assign col_ok = (cmd_i.data <= cmd_data_t'(MAX_COL));
    assign row_ok = (cmd_i.data <= cmd_data_t'(MAX_ROW));

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            roi_col_o   <= DEFAULT_COL;
            roi_row_o   <= DEFAULT_ROW;
            stream_en_o <= 1'b1;
        end else if (cmd_valid_i) begin
            case (cmd_i.addr)
                ADDR_ROI_COL:   if (col_ok) roi_col_o <= coord_t'(cmd_i.data);
                ADDR_ROI_ROW:   if (row_ok) roi_row_o <= coord_t'(cmd_i.data);
                ADDR_STREAM_EN: stream_en_o <= cmd_i.data[0];
                // unknown addresses fall through untouched
                default: ;
            endcase
        end
    end

endmodule

/* src/roi_cropper.sv */
module roi_cropper #(
    parameter int IMAGE_WIDTH  = 16,
    parameter int IMAGE_HEIGHT = 6,
    parameter int ROI_WIDTH    = 10,
    parameter int ROI_HEIGHT   = 4
) (
    input  logic                          core_clk,
    input  logic                          sys_reset,

    input  frame_link_pkg::stereo_pixel_t pixel_i,
    input  logic                          pixel_valid_i,
    input  logic                          pixel_sof_i,

    input  frame_link_pkg::coord_t        roi_col_i,
    input  frame_link_pkg::coord_t        roi_row_i,
    input  logic                          stream_en_i,

    output logic                          push_o,
    output frame_link_pkg::pixel_beat_t   push_beat_o
);
    import frame_link_pkg::*;

    coord_t col_q, row_q, col_next, row_next;
    coord_t cur_col, cur_row;
    coord_t frame_col_q, frame_row_q, win_col, win_row;
    logic   frame_en_q, win_en;
    logic   first_q;
    logic   sof_hit, in_window, take;

    assign sof_hit = pixel_valid_i && pixel_sof_i;

    //////////////////////////////
    // raster position
    always_comb begin
        col_next = col_q;
        row_next = row_q;
        if (pixel_valid_i) begin
            col_next = col_q + 16'd1;
            if (col_q == coord_t'(IMAGE_WIDTH - 1)) begin
                col_next = '0;
                row_next = row_q + 16'd1;
                if (row_q == coord_t'(IMAGE_HEIGHT - 1)) begin
                    row_next = '0;
                end
            end
        end
        // sof pixel is (0,0), the next one is column 1
        if (sof_hit) begin
            col_next = 16'd1;
            row_next = '0;
        end
    end

    assign cur_col = sof_hit ? '0 : col_q;
    assign cur_row = sof_hit ? '0 : row_q;

    //////////////////////////////
    // window of the current frame
    assign win_col = sof_hit ? roi_col_i   : frame_col_q;
    assign win_row = sof_hit ? roi_row_i   : frame_row_q;
    assign win_en  = sof_hit ? stream_en_i : frame_en_q;

    assign in_window = (cur_col >= win_col) && ((cur_col - win_col) < coord_t'(ROI_WIDTH))
                    && (cur_row >= win_row) && ((cur_row - win_row) < coord_t'(ROI_HEIGHT));
    assign take = pixel_valid_i && win_en && in_window;

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            col_q       <= '0;
            row_q       <= '0;
            frame_col_q <= '0;
            frame_row_q <= '0;
            frame_en_q  <= 1'b0;
            first_q     <= 1'b0;
            push_o      <= 1'b0;
        end else begin
            col_q  <= col_next;
            row_q  <= row_next;
            push_o <= take;
            if (sof_hit) begin
                frame_col_q <= roi_col_i;
                frame_row_q <= roi_row_i;
                frame_en_q  <= stream_en_i;
                first_q     <= !take;
            end else if (take) begin
                first_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        push_beat_o.pix <= pixel_i;
        push_beat_o.sof <= sof_hit || first_q;
    end

endmodule

/* src/pixel_fifo.sv */
module pixel_fifo #(
    parameter int FIFO_DEPTH = 32
) (
    input  logic                        core_clk,
    input  logic                        sys_reset,

    input  logic                        push_i,
    input  frame_link_pkg::pixel_beat_t push_beat_i,

    input  logic                        pop_i,
    output frame_link_pkg::pixel_beat_t head_beat_o,
    output logic                        not_empty_o
);
    import frame_link_pkg::*;

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    pixel_beat_t mem [FIFO_DEPTH];

    logic [ADDR_W-1:0] wr_ptr_q;
    logic [ADDR_W-1:0] rd_ptr_q;
    logic [ADDR_W:0]   count_q;
    logic              full;
    logic              wr_en;
    logic              rd_en;

    assign full  = (count_q == (ADDR_W + 1)'(FIFO_DEPTH));
    assign wr_en = push_i && !full;
    assign rd_en = pop_i && not_empty_o;

    always_ff @(posedge core_clk) begin
        if (wr_en) begin
            mem[wr_ptr_q] <= push_beat_i;
        end
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (rd_en) rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_q + (ADDR_W + 1)'(wr_en) - (ADDR_W + 1)'(rd_en);
        end
    end

    // show-ahead read
    assign head_beat_o = mem[rd_ptr_q];
    assign not_empty_o = (count_q != '0);

endmodule

/* src/frame_serializer.sv */
module frame_serializer (
    input  logic                        core_clk,
    input  logic                        sys_reset,

    input  frame_link_pkg::pixel_beat_t head_beat_i,
    input  logic                        not_empty_i,
    output logic                        pop_o,

    input  logic                        tx_stall_i,
    output frame_link_pkg::pixel_byte_t tx_byte_o,
    output logic                        tx_valid_o
);
    import frame_link_pkg::*;

    localparam logic [2:0] HDR_LAST = 3'd7;

    ser_state_t  state_q;
    logic [2:0]  hdr_idx_q;
    logic        hdr_done_q;
    logic        chan_q;
    logic        stall_q;
    logic        need_hdr;
    logic        has_byte;
    pixel_byte_t hdr_byte;
    pixel_byte_t pix_byte;

    //////////////////////////////
    // byte selection
    always_comb begin
        hdr_byte = MAGIC_NUM[8 * (7 - hdr_idx_q) +: 8];
        pix_byte = chan_q ? head_beat_i.pix.ch1 : head_beat_i.pix.ch0;
        need_hdr = head_beat_i.sof && !hdr_done_q;
        has_byte = (state_q == HEADER) || (not_empty_i && !need_hdr);
    end

    // sink sees stall one cycle late, so gate on last cycle's level
    assign tx_valid_o = has_byte && !stall_q;
    assign tx_byte_o  = (state_q == HEADER) ? hdr_byte : pix_byte;
    assign pop_o      = tx_valid_o && (state_q == PIXEL) && chan_q;

    //////////////////////////////
    // FSM
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            state_q    <= PIXEL;
            hdr_idx_q  <= '0;
            hdr_done_q <= 1'b0;
            chan_q     <= 1'b0;
            stall_q    <= 1'b1;
        end else begin
            stall_q <= tx_stall_i;
            case (state_q)
                HEADER: begin
                    if (tx_valid_o) begin
                        hdr_idx_q <= hdr_idx_q + 3'd1;
                        if (hdr_idx_q == HDR_LAST) begin
                            state_q    <= PIXEL;
                            hdr_done_q <= 1'b1;
                        end
                    end
                end
                PIXEL: begin
                    // new frame at the head, header goes out first
                    if (not_empty_i && need_hdr) begin
                        state_q   <= HEADER;
                        hdr_idx_q <= '0;
                    end else if (tx_valid_o) begin
                        chan_q <= !chan_q;
                        if (chan_q) hdr_done_q <= 1'b0;
                    end
                end
                default: state_q <= PIXEL;
            endcase
        end
    end

endmodule

/* src/stereo_frame_link.sv */
module stereo_frame_link #(
    parameter int IMAGE_WIDTH  = 16,
    parameter int IMAGE_HEIGHT = 6,
    parameter int ROI_WIDTH    = 10,
    parameter int ROI_HEIGHT   = 4,
    parameter int FIFO_DEPTH   = 32
) (
    input  logic                          core_clk,
    input  logic                          sys_reset,

    // host command bytes
    input  frame_link_pkg::pixel_byte_t   host_byte_i,
    input  logic                          host_valid_i,

    // stereo pixel stream
    input  frame_link_pkg::stereo_pixel_t pixel_i,
    input  logic                          pixel_valid_i,
    input  logic                          pixel_sof_i,

    // byte sink
    input  logic                          tx_stall_i,
    output frame_link_pkg::pixel_byte_t   tx_byte_o,
    output logic                          tx_valid_o
);
    import frame_link_pkg::*;

    //////////////////////////////
    // command path
    command_t    cmd;
    logic        cmd_valid;
    coord_t      roi_col;
    coord_t      roi_row;
    logic        stream_en;

    command_assembler u_cmd_asm (
        .core_clk    (core_clk),
        .sys_reset   (sys_reset),
        .host_byte_i (host_byte_i),
        .host_valid_i(host_valid_i),
        .cmd_o       (cmd),
        .cmd_valid_o (cmd_valid)
    );

    roi_registers #(
        .IMAGE_WIDTH (IMAGE_WIDTH),
        .IMAGE_HEIGHT(IMAGE_HEIGHT),
        .ROI_WIDTH   (ROI_WIDTH),
        .ROI_HEIGHT  (ROI_HEIGHT)
    ) u_roi_regs (
        .core_clk   (core_clk),
        .sys_reset  (sys_reset),
        .cmd_i      (cmd),
        .cmd_valid_i(cmd_valid),
        .roi_col_o  (roi_col),
        .roi_row_o  (roi_row),
        .stream_en_o(stream_en)
    );

    //////////////////////////////
    // pixel path
    logic        push;
    pixel_beat_t push_beat;
    pixel_beat_t head_beat;
    logic        not_empty;
    logic        pop;

    roi_cropper #(
        .IMAGE_WIDTH (IMAGE_WIDTH),
        .IMAGE_HEIGHT(IMAGE_HEIGHT),
        .ROI_WIDTH   (ROI_WIDTH),
        .ROI_HEIGHT  (ROI_HEIGHT)
    ) u_cropper (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .pixel_i      (pixel_i),
        .pixel_valid_i(pixel_valid_i),
        .pixel_sof_i  (pixel_sof_i),
        .roi_col_i    (roi_col),
        .roi_row_i    (roi_row),
        .stream_en_i  (stream_en),
        .push_o       (push),
        .push_beat_o  (push_beat)
    );

    pixel_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .core_clk   (core_clk),
        .sys_reset  (sys_reset),
        .push_i     (push),
        .push_beat_i(push_beat),
        .pop_i      (pop),
        .head_beat_o(head_beat),
        .not_empty_o(not_empty)
    );

    frame_serializer u_serializer (
        .core_clk   (core_clk),
        .sys_reset  (sys_reset),
        .head_beat_i(head_beat),
        .not_empty_i(not_empty),
        .pop_o      (pop),
        .tx_stall_i (tx_stall_i),
        .tx_byte_o  (tx_byte_o),
        .tx_valid_o (tx_valid_o)
    );

endmodule

/* tb/frame_link_checker.sv */
module frame_link_checker (
    input logic                        core_clk,
    input logic                        sys_reset,
    input logic                        tx_stall_i,
    input frame_link_pkg::pixel_byte_t tx_byte_i,
    input logic                        tx_valid_i
);
    int assert_errors = 0;

    // quiet through reset and the first cycle after it
    reset_quiet: assert property (@(posedge core_clk) sys_reset |=> !tx_valid_i)
        else begin
            assert_errors++;
            $error("tx_valid_o high during reset or the cycle after it");
        end

    stall_respected: assert property (@(posedge core_clk) disable iff (sys_reset)
            tx_stall_i |=> !tx_valid_i)
        else begin
            assert_errors++;
            $error("tx_valid_o high in the cycle after a stalled cycle");
        end

    byte_known: assert property (@(posedge core_clk) disable iff (sys_reset)
            tx_valid_i |-> !$isunknown(tx_byte_i))
        else begin
            assert_errors++;
            $error("tx_byte_o unknown while tx_valid_o is high");
        end

endmodule

bind stereo_frame_link frame_link_checker u_checker (
    .core_clk  (core_clk),
    .sys_reset (sys_reset),
    .tx_stall_i(tx_stall_i),
    .tx_byte_i (tx_byte_o),
    .tx_valid_i(tx_valid_o)
);

/* tb/frame_link_monitor.sv */
module frame_link_monitor #(
    parameter int IMAGE_WIDTH  = 16,
    parameter int IMAGE_HEIGHT = 6,
    parameter int ROI_WIDTH    = 10,
    parameter int ROI_HEIGHT   = 4
) (
    input  logic                          core_clk,
    input  logic                          sys_reset,
    input  frame_link_pkg::pixel_byte_t   host_byte_i,
    input  logic                          host_valid_i,
    input  frame_link_pkg::stereo_pixel_t pixel_i,
    input  logic                          pixel_valid_i,
    input  logic                          pixel_sof_i,
    input  frame_link_pkg::pixel_byte_t   tx_byte_i,
    input  logic                          tx_valid_i,
    output int                            mismatch_cnt_o,
    output int                            extra_cnt_o,
    output int                            pending_o
);
    import frame_link_pkg::*;

    localparam logic [63:0] MAGIC_TEXT = "BIVFRAME";
    localparam int          CMD_LEN    = 6;

    pixel_byte_t exp_q [$];
    logic [47:0] cmd_shift;
    logic [47:0] cmd_stage1;
    logic [47:0] cmd_stage2;
    logic        valid_stage1;
    logic        valid_stage2;
    int          cmd_bytes;
    int          reg_col;
    int          reg_row;
    logic        reg_en;
    int          col;
    int          row;
    int          win_col;
    int          win_row;
    logic        win_en;
    logic        hdr_sent;

    // register rules, with the bound check on the window
    task automatic apply_command(input logic [47:0] cmd);
        if (cmd[47:32] == 16'h0000) begin
            if (cmd[31:16] == '0 && int'(cmd[15:0]) + ROI_WIDTH <= IMAGE_WIDTH) begin
                reg_col = int'(cmd[15:0]);
            end
        end else if (cmd[47:32] == 16'h0001) begin
            if (cmd[31:16] == '0 && int'(cmd[15:0]) + ROI_HEIGHT <= IMAGE_HEIGHT) begin
                reg_row = int'(cmd[15:0]);
            end
        end else if (cmd[47:32] == 16'h0002) begin
            reg_en = cmd[0];
        end
    endtask

    task automatic take_pixel();
        if (pixel_sof_i) begin
            col      = 0;
            row      = 0;
            win_col  = reg_col;
            win_row  = reg_row;
            win_en   = reg_en;
            hdr_sent = 1'b0;
        end
        if (win_en && col >= win_col && col < win_col + ROI_WIDTH
                && row >= win_row && row < win_row + ROI_HEIGHT) begin
            // header goes ahead of the first kept pixel
            if (!hdr_sent) begin
                for (int i = 7; i >= 0; i--) begin
                    exp_q.push_back(MAGIC_TEXT[8 * i +: 8]);
                end
                hdr_sent = 1'b1;
            end
            exp_q.push_back(pixel_i.ch0);
            exp_q.push_back(pixel_i.ch1);
        end
        col++;
        if (col == IMAGE_WIDTH) begin
            col = 0;
            row++;
            if (row == IMAGE_HEIGHT) begin
                row = 0;
            end
        end
    endtask

    //////////////////////////////
    // input side model
    always @(posedge core_clk) begin
        if (sys_reset) begin
            reg_col      = (IMAGE_WIDTH - ROI_WIDTH) / 2;
            reg_row      = 0;
            reg_en       = 1'b1;
            win_en       = 1'b0;
            hdr_sent     = 1'b0;
            col          = 0;
            row          = 0;
            cmd_bytes    = 0;
            valid_stage1 = 1'b0;
            valid_stage2 = 1'b0;
            exp_q.delete();
        end else begin
            // pixels see a new register value two edges after the last command byte
            if (valid_stage2) begin
                apply_command(cmd_stage2);
            end
            if (pixel_valid_i) begin
                take_pixel();
            end
            valid_stage2 = valid_stage1;
            cmd_stage2   = cmd_stage1;
            valid_stage1 = 1'b0;
            if (host_valid_i) begin
                cmd_shift = {cmd_shift[39:0], host_byte_i};
                if (cmd_bytes == CMD_LEN - 1) begin
                    cmd_bytes    = 0;
                    cmd_stage1   = cmd_shift;
                    valid_stage1 = 1'b1;
                end else begin
                    cmd_bytes++;
                end
            end
        end
    end

    //////////////////////////////
    // output compare, away from the clock edge
    always @(negedge core_clk) begin : check_output
        pixel_byte_t exp_byte;
        if (sys_reset) begin
            mismatch_cnt_o = 0;
            extra_cnt_o    = 0;
        end else if (tx_valid_i) begin
            if (exp_q.size() == 0) begin
                extra_cnt_o++;
                $display("unexpected byte %02h on tx_byte_o at time %0t, none was due",
                         tx_byte_i, $time);
            end else begin
                exp_byte = exp_q.pop_front();
                if (tx_byte_i !== exp_byte) begin
                    mismatch_cnt_o++;
                    $display("Error at time %0t: tx_byte_o expected %02h, actual %02h",
                             $time, exp_byte, tx_byte_i);
                end
            end
        end
        pending_o = exp_q.size();
    end

endmodule

/* tb/tb_stereo_frame_link.sv */
module tb_stereo_frame_link;
    import frame_link_pkg::*;

    localparam int IMAGE_WIDTH  = 16;
    localparam int IMAGE_HEIGHT = 6;
    localparam int ROI_WIDTH    = 10;
    localparam int ROI_HEIGHT   = 4;
    localparam int FIFO_DEPTH   = 32;
    // frames, max stall, command count, command 0, command 1
    localparam int REC_WORDS    = 5;
    localparam int MAX_WORDS    = 64;
    // cycles allowed for the output to catch up after the last frame
    localparam int DRAIN_CYCLES = 1000;

    logic          core_clk = 1'b0;
    logic          sys_reset;
    pixel_byte_t   host_byte;
    logic          host_valid;
    stereo_pixel_t pixel;
    logic          pixel_valid;
    logic          pixel_sof;
    logic          tx_stall;
    pixel_byte_t   tx_byte;
    logic          tx_valid;

    logic [47:0] patterns [MAX_WORDS];
    integer      pix_seed = 32'h7bfc;
    integer      stall_seed = 32'h7bfc;
    int          max_stall = 0;
    int          watchdog_cycles = 0;
    int          mismatch_cnt;
    int          extra_cnt;
    int          pending;

    always #5 core_clk = ~core_clk;

    stereo_frame_link #(
        .IMAGE_WIDTH (IMAGE_WIDTH),
        .IMAGE_HEIGHT(IMAGE_HEIGHT),
        .ROI_WIDTH   (ROI_WIDTH),
        .ROI_HEIGHT  (ROI_HEIGHT),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) uut (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .host_byte_i  (host_byte),
        .host_valid_i (host_valid),
        .pixel_i      (pixel),
        .pixel_valid_i(pixel_valid),
        .pixel_sof_i  (pixel_sof),
        .tx_stall_i   (tx_stall),
        .tx_byte_o    (tx_byte),
        .tx_valid_o   (tx_valid)
    );

    frame_link_monitor #(
        .IMAGE_WIDTH (IMAGE_WIDTH),
        .IMAGE_HEIGHT(IMAGE_HEIGHT),
        .ROI_WIDTH   (ROI_WIDTH),
        .ROI_HEIGHT  (ROI_HEIGHT)
    ) mon (
        .core_clk      (core_clk),
        .sys_reset     (sys_reset),
        .host_byte_i   (host_byte),
        .host_valid_i  (host_valid),
        .pixel_i       (pixel),
        .pixel_valid_i (pixel_valid),
        .pixel_sof_i   (pixel_sof),
        .tx_byte_i     (tx_byte),
        .tx_valid_i    (tx_valid),
        .mismatch_cnt_o(mismatch_cnt),
        .extra_cnt_o   (extra_cnt),
        .pending_o     (pending)
    );

    // six bytes, msb first, one per cycle
    task automatic send_command(input logic [47:0] cmd);
        for (int b = 0; b < 6; b++) begin
            @(posedge core_clk);
            #1;
            host_byte  = cmd[8 * (5 - b) +: 8];
            host_valid = 1'b1;
        end
        @(posedge core_clk);
        #1;
        host_valid = 1'b0;
    endtask

    // one raster frame, a pixel every third cycle
    task automatic send_frame();
        for (int row = 0; row < IMAGE_HEIGHT; row++) begin
            for (int col = 0; col < IMAGE_WIDTH; col++) begin
                @(posedge core_clk);
                #1;
                pixel.ch0   = 8'(row * 16 + col);
                pixel.ch1   = 8'($random(pix_seed));
                pixel_valid = 1'b1;
                pixel_sof   = (row == 0) && (col == 0);
                @(posedge core_clk);
                #1;
                pixel_valid = 1'b0;
                pixel_sof   = 1'b0;
                @(posedge core_clk);
            end
        end
    endtask

    //////////////////////////////
    // stimulus
    initial begin : stimulus
        int rec;
        int base;
        int total_frames;
        int errors;
        int drain;
        sys_reset  = 1'b1;
        host_byte  = '0;
        host_valid = 1'b0;
        pixel      = '0;
        pixel_valid = 1'b0;
        pixel_sof  = 1'b0;
        for (int i = 0; i < MAX_WORDS; i++) begin
            patterns[i] = '0;
        end
        $readmemh("tb/frame_link_patterns.txt", patterns);

        total_frames = 0;
        rec = 0;
        while (rec * REC_WORDS < MAX_WORDS && patterns[rec * REC_WORDS] != '0) begin
            total_frames += int'(patterns[rec * REC_WORDS]);
            rec++;
        end
        watchdog_cycles = total_frames * IMAGE_WIDTH * IMAGE_HEIGHT * 3 + 2000;

        repeat (16) @(posedge core_clk);
        #1;
        sys_reset = 1'b0;
        repeat (4) @(posedge core_clk);

        rec = 0;
        while (rec * REC_WORDS < MAX_WORDS && patterns[rec * REC_WORDS] != '0) begin
            base = rec * REC_WORDS;
            max_stall = int'(patterns[base + 1]);
            for (int c = 0; c < int'(patterns[base + 2]); c++) begin
                send_command(patterns[base + 3 + c]);
            end
            // let the register update land before the next sof
            repeat (4) @(posedge core_clk);
            for (int f = 0; f < int'(patterns[base]); f++) begin
                send_frame();
            end
            rec++;
        end

        drain = 0;
        while (pending != 0 && drain < DRAIN_CYCLES) begin
            @(posedge core_clk);
            drain++;
        end
        repeat (20) @(posedge core_clk);

        if (pending != 0) begin
            $display("%0d expected bytes never appeared on tx_byte_o", pending);
        end
        errors = mismatch_cnt + extra_cnt + pending + uut.u_checker.assert_errors;
        $display("errors: %0d mismatched, %0d unexpected, %0d missing, %0d assertion failures",
                 mismatch_cnt, extra_cnt, pending, uut.u_checker.assert_errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // random stall bursts, then a fixed open window
    initial begin : stall_gen
        integer burst;
        tx_stall = 1'b0;
        forever begin
            burst = $unsigned($random(stall_seed)) % (max_stall + 1);
            if (burst > 8) begin
                burst = 8;
            end
            repeat (burst) begin
                @(posedge core_clk);
                #1;
                tx_stall = 1'b1;
            end
            repeat (8) begin
                @(posedge core_clk);
                #1;
                tx_stall = 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge core_clk);
        $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("Test failed");
        $finish;
    end

endmodule

/* tb/frame_link_patterns.txt */
// one test per line: frames, max stall, command count, command 0, command 1
// a command is 16-bit address then 32-bit data; a line of zeros ends the list
// default centred window
2 0 0 000000000000 000000000000
// move the corner to column 3, row 2
1 0 2 000000000003 000100000002
// column 7 leaves the image and address 5 is unknown, both ignored
1 3 2 000000000007 000500000001
// streaming off, frame suppressed
1 0 1 000200000000 000000000000
// streaming back on
1 4 1 000200000001 000000000000
// right edge window under long stalls
2 8 2 000000000006 000100000000
// row 3 leaves the image, ignored
1 8 1 000100000003 000000000000
0 0 0 000000000000 000000000000

/* stereo_frame_link.f */
src/frame_link_pkg.sv
src/command_assembler.sv
src/roi_registers.sv
src/roi_cropper.sv
src/pixel_fifo.sv
src/frame_serializer.sv
src/stereo_frame_link.sv
tb/frame_link_checker.sv
tb/frame_link_monitor.sv
tb/tb_stereo_frame_link.sv

/* Makefile */
# Verilator build and run of the stereo frame link testbench

VERILATOR ?= verilator
TOP       ?= tb_stereo_frame_link
FLIST     ?= stereo_frame_link.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

PASS_MSG = Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)
